//--- hdl/albuf_bus_pkg.sv
package albuf_bus_pkg;

  //////////////////////////////
  // Fetch bus limits and markers
  //////////////////////////////

  // Bus requests allowed in flight at once
  parameter int unsigned MAX_OUTSTANDING = 2;

  // Low two bits of a halfword that starts a 32-bit instruction
  parameter logic [1:0] OPCODE_FULL = 2'b11;

  //////////////////////////////
  // Bus response and output types
  //////////////////////////////

  // One word returned by the fetch bus
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } fetch_resp_t;

  // One whole instruction handed to decode
  typedef struct packed {
    logic [31:0] instr;
    // Set if any word the instruction came from faulted
    logic        err;
    logic [31:0] addr;
  } instr_out_t;

endpackage

//--- hdl/albuf_ctrl_pkg.sv
package albuf_ctrl_pkg;

  //////////////////////////////
  // Controller to buffer
  //////////////////////////////

  // Branch and fetch control from the core controller
  typedef struct packed {
    // Fetch enable, held as a level
    logic        instr_req;
    // Single-cycle pulse that redirects fetch to target
    logic        pc_set;
    // Single-cycle pulse that drops everything buffered
    logic        kill;
    // Branch destination, halfword aligned
    logic [31:0] target;
  } branch_ctrl_t;

  //////////////////////////////
  // Write-side tracking state
  //////////////////////////////

  // Where the next incoming word sits relative to instruction boundaries
  // Used to count complete instructions as words arrive
  typedef enum logic [1:0] {
    // Next word starts on an instruction boundary
    ALIGNED  = 2'd0,
    // Branch target was in the upper half
    // Lower half of the next word is not part of the stream
    SKIP_LOW = 2'd1,
    // Lower half of the next word ends a 32-bit instruction
    SPLIT    = 2'd2
  } align_state_e;

  // Tracking state right after a branch
  function automatic align_state_e branch_state(input logic [31:0] target);
    branch_state = target[1] ? SKIP_LOW : ALIGNED;
  endfunction

endpackage

//--- hdl/albuf_fetch_ctrl.sv
module albuf_fetch_ctrl #(
  parameter int unsigned DEPTH = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  albuf_ctrl_pkg::branch_ctrl_t ctrl_i,
  output logic                         fetch_valid_o,
  input  logic                         fetch_ready_i,
  output logic                         fetch_branch_o,
  output logic [31:0]                  fetch_branch_addr_o,
  input  logic                         resp_valid_i,
  input  logic [31:0]                  resp_rdata_i,
  input  logic                         pop_i,
  output logic                         resp_accept_o,
  output logic                         busy_o
);
  import albuf_bus_pkg::*;
  import albuf_ctrl_pkg::*;

  // Each buffered word can hold up to two instructions
  localparam int unsigned ICNT_W = $clog2(2 * DEPTH + 1);
  localparam int unsigned OCNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [OCNT_W-1:0] out_cnt_q, out_cnt_n;
  logic [OCNT_W-1:0] flush_q, flush_n, flush_branch;
  logic [ICNT_W-1:0] instr_cnt_q, instr_cnt_n, pend_cnt;
  align_state_e      state_q, state_n;
  logic [1:0]        n_incoming;
  logic              pop_q;
  logic              req_fire;
  logic              hi_full, lo_full;

  //////////////////////////////
  // Fetch request decision
  //////////////////////////////

  // Emission counted one cycle late to keep ready out of this path
  assign pend_cnt = instr_cnt_q - ICNT_W'(pop_q);

  // Fetch when low on instructions, or on a branch, with room in flight
  assign fetch_valid_o = ctrl_i.instr_req &&
                         (out_cnt_q < OCNT_W'(MAX_OUTSTANDING)) &&
                         (ctrl_i.pc_set ||
                          (pend_cnt == '0) ||
                          ((pend_cnt == ICNT_W'(1)) && (out_cnt_q == '0)));

  assign req_fire            = fetch_valid_o && fetch_ready_i;
  assign fetch_branch_o      = ctrl_i.pc_set;
  assign fetch_branch_addr_o = {ctrl_i.target[31:1], 1'b0};
  assign busy_o              = (out_cnt_q != '0) || fetch_valid_o;

  // Stale words are dropped, as is a word landing on a branch or kill
  assign resp_accept_o = resp_valid_i && (flush_q == '0) && !ctrl_i.pc_set && !ctrl_i.kill;

  // Outstanding requests
  assign out_cnt_n = out_cnt_q + OCNT_W'(req_fire) - OCNT_W'(resp_valid_i);

  // Every word still owed at a branch belongs to the old path
  // A word arriving right now is already accounted for
  assign flush_branch = out_cnt_q - OCNT_W'(resp_valid_i);

  always_comb begin
    flush_n = flush_q;
    if (ctrl_i.pc_set) begin
      flush_n = flush_branch;
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - OCNT_W'(1);
    end
  end

  //////////////////////////////
  // Complete instruction tracking
  //////////////////////////////

  assign lo_full = (resp_rdata_i[1:0] == OPCODE_FULL);
  assign hi_full = (resp_rdata_i[17:16] == OPCODE_FULL);

  always_comb begin
    state_n    = state_q;
    n_incoming = 2'd0;
    if (ctrl_i.pc_set) begin
      state_n = branch_state(ctrl_i.target);
    end else if (resp_accept_o) begin
      case (state_q)
        // Whole word is one 32-bit instruction, or lower half compressed
        ALIGNED: begin
          if (lo_full) begin
            n_incoming = 2'd1;
          end else begin
            n_incoming = hi_full ? 2'd1 : 2'd2;
            state_n    = hi_full ? SPLIT : ALIGNED;
          end
        end
        // Only the upper half counts
        SKIP_LOW: begin
          n_incoming = hi_full ? 2'd0 : 2'd1;
          state_n    = hi_full ? SPLIT : ALIGNED;
        end
        // Lower half closes the pending instruction
        default: begin
          n_incoming = hi_full ? 2'd1 : 2'd2;
          state_n    = hi_full ? SPLIT : ALIGNED;
        end
      endcase
    end
  end

  always_comb begin
    if (ctrl_i.pc_set || ctrl_i.kill) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + ICNT_W'(n_incoming) - ICNT_W'(pop_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q   <= '0;
      flush_q     <= '0;
      instr_cnt_q <= '0;
      state_q     <= ALIGNED;
      pop_q       <= 1'b0;
    end else begin
      out_cnt_q   <= out_cnt_n;
      flush_q     <= flush_n;
      instr_cnt_q <= instr_cnt_n;
      state_q     <= state_n;
      pop_q       <= pop_i;
    end
  end

  // Request limit holds over any mix of grants and responses
  assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= OCNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above limit");

  // Bus never answers a request it was not given
  assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (out_cnt_q != '0))
    else $error("response with no request in flight");

endmodule

//--- hdl/albuf_word_queue.sv
module albuf_word_queue #(
  parameter int unsigned DEPTH = 3
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       clear_i,
  input  logic                       kill_i,
  input  logic                       push_i,
  input  albuf_bus_pkg::fetch_resp_t push_data_i,
  input  logic                       advance_i,
  output albuf_bus_pkg::fetch_resp_t head_o,
  output logic                       head_valid_o,
  output albuf_bus_pkg::fetch_resp_t next_o,
  output logic                       next_valid_o
);
  import albuf_bus_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);

  fetch_resp_t            mem_q [DEPTH];
  logic [DEPTH-1:0]       valid_q, valid_n;
  logic [PTR_W-1:0]       wptr_q, rptr_q, rptr2;

  // Step a pointer, wrapping after the last entry
  function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      wrap_inc = '0;
    end else begin
      wrap_inc = ptr + PTR_W'(1);
    end
  endfunction

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Entry after the head supplies the lower half of a split instruction
  assign rptr2 = wrap_inc(rptr_q);

  assign head_o       = mem_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_o       = mem_q[rptr2];
  assign next_valid_o = valid_q[rptr2];

  //////////////////////////////
  // Valid bits and pointers
  //////////////////////////////

  // Set before clear so a bypassed word that is consumed at once
  // leaves its slot empty
  always_comb begin
    valid_n = valid_q;
    if (push_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (advance_i) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      valid_q <= '0;
    end else if (clear_i) begin
      // Branch starts from an empty queue at slot zero
      wptr_q  <= '0;
      rptr_q  <= '0;
      valid_q <= '0;
    end else if (kill_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
      if (push_i) begin
        wptr_q <= wrap_inc(wptr_q);
      end
      if (advance_i) begin
        rptr_q <= wrap_inc(rptr_q);
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  // Request throttling upstream must keep a free slot for every word
  assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !valid_q[wptr_q])
    else $error("push into occupied queue entry");

endmodule

//--- hdl/albuf_aligner.sv
module albuf_aligner (
  input  logic                         clk,
  input  logic                         rst_n,
  input  albuf_ctrl_pkg::branch_ctrl_t ctrl_i,
  input  albuf_bus_pkg::fetch_resp_t   head_i,
  input  logic                         head_valid_i,
  input  albuf_bus_pkg::fetch_resp_t   next_i,
  input  logic                         next_valid_i,
  input  logic                         resp_accept_i,
  input  albuf_bus_pkg::fetch_resp_t   resp_i,
  output logic                         instr_valid_o,
  input  logic                         instr_ready_i,
  output albuf_bus_pkg::instr_out_t    instr_o,
  output logic                         advance_o,
  output logic                         pop_o
);
  import albuf_bus_pkg::*;

  logic [31:0]  addr_q, addr_n, addr_incr;
  fetch_resp_t  word, hi_word;
  logic         word_ok, split_ok;
  logic         aligned_c, unaligned_c;
  logic         fire;

  //////////////////////////////
  // Source selection
  //////////////////////////////

  // Head word if buffered, else the response on the bus this cycle
  assign word    = head_valid_i ? head_i : resp_i;
  assign word_ok = head_valid_i || resp_accept_i;

  // Second word of a split instruction
  assign hi_word  = next_valid_i ? next_i : resp_i;
  assign split_ok = next_valid_i || (head_valid_i && resp_accept_i);

  // Compressed checks only matter while the output is valid
  assign aligned_c   = (word.rdata[1:0] != OPCODE_FULL);
  assign unaligned_c = (word.rdata[17:16] != OPCODE_FULL);

  //////////////////////////////
  // Output instruction
  //////////////////////////////

  always_comb begin
    instr_o.addr  = addr_q;
    instr_o.instr = word.rdata;
    instr_o.err   = word.err;
    if (addr_q[1]) begin
      // Upper half of head, lower half of the following word
      instr_o.instr = {hi_word.rdata[15:0], word.rdata[31:16]};
      if (!unaligned_c) begin
        instr_o.err = word.err || hi_word.err;
      end
    end
  end

  always_comb begin
    if (ctrl_i.kill || ctrl_i.pc_set) begin
      // Old path is being dropped
      instr_valid_o = 1'b0;
    end else if (addr_q[1] && !unaligned_c) begin
      instr_valid_o = split_ok;
    end else begin
      instr_valid_o = word_ok;
    end
  end

  assign fire  = instr_valid_o && instr_ready_i;
  assign pop_o = fire;

  // Head word is used up once nothing of it is left for the next instruction
  assign advance_o = fire && (addr_q[1] || !aligned_c);

  //////////////////////////////
  // Halfword address
  //////////////////////////////

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  always_comb begin
    if (addr_q[1]) begin
      // A split 32-bit instruction ends mid-word
      addr_n = {addr_incr[31:2], unaligned_c ? 2'b00 : 2'b10};
    end else if (aligned_c) begin
      addr_n = {addr_q[31:2], 2'b10};
    end else begin
      addr_n = addr_incr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (ctrl_i.pc_set) begin
      addr_q <= {ctrl_i.target[31:1], 1'b0};
    end else if (fire) begin
      addr_q <= addr_n;
    end
  end

endmodule

//--- hdl/albuf_top.sv
module albuf_top #(
  parameter int unsigned DEPTH = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  albuf_ctrl_pkg::branch_ctrl_t ctrl_i,
  output logic                         fetch_valid_o,
  input  logic                         fetch_ready_i,
  output logic                         fetch_branch_o,
  output logic [31:0]                  fetch_branch_addr_o,
  input  logic                         resp_valid_i,
  input  albuf_bus_pkg::fetch_resp_t   resp_i,
  output logic                         instr_valid_o,
  input  logic                         instr_ready_i,
  output albuf_bus_pkg::instr_out_t    instr_o,
  output logic                         busy_o
);
  import albuf_bus_pkg::*;

  // Stage to stage strobes
  logic        resp_accept;
  logic        pop;
  logic        advance;

  // Queue read side
  fetch_resp_t head, next;
  logic        head_valid, next_valid;

  //////////////////////////////
  // Request stage
  //////////////////////////////

  albuf_fetch_ctrl #(
    .DEPTH (DEPTH)
  ) u_fetch_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_i              (ctrl_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_i.rdata),
    .pop_i               (pop),
    .resp_accept_o       (resp_accept),
    .busy_o              (busy_o)
  );

  // Word storage
  albuf_word_queue #(
    .DEPTH (DEPTH)
  ) u_word_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (ctrl_i.pc_set),
    .kill_i       (ctrl_i.kill),
    .push_i       (resp_accept),
    .push_data_i  (resp_i),
    .advance_i    (advance),
    .head_o       (head),
    .head_valid_o (head_valid),
    .next_o       (next),
    .next_valid_o (next_valid)
  );

  // Output stage
  albuf_aligner u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .head_i        (head),
    .head_valid_i  (head_valid),
    .next_i        (next),
    .next_valid_i  (next_valid),
    .resp_accept_i (resp_accept),
    .resp_i        (resp_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .advance_o     (advance),
    .pop_o         (pop)
  );

endmodule

//--- bench/albuf_tb.sv
module albuf_tb;
  import albuf_bus_pkg::*;
  import albuf_ctrl_pkg::*;

  // One program block with its branch target and run conditions
  typedef struct packed {
    logic [31:0]      target;
    // Halfword 7 in the top bits, halfword 0 in the bottom
    logic [7:0][15:0] hw;
    // Bus error flag per word of the block
    logic [3:0]       err;
    logic             kill;
    logic             rand_ready;
  } row_t;

  localparam int NUM_ROWS       = 6;
  localparam int TIMEOUT_CYCLES = 200 * NUM_ROWS;
  // Cycles from request transfer to response, so two can be in flight
  localparam int RESP_LATENCY   = 2;
  localparam int SETTLE         = 2;

  logic         clk;
  logic         rst_n;
  branch_ctrl_t ctrl;
  logic         fetch_valid, fetch_ready, fetch_branch;
  logic [31:0]  fetch_branch_addr;
  logic         resp_valid;
  fetch_resp_t  resp;
  logic         instr_valid, instr_ready;
  instr_out_t   instr_out;
  logic         busy;

  row_t         rows [NUM_ROWS];
  row_t         cur;
  // Expected instruction stream of the current row
  logic [31:0]  exp_addr [$];
  logic [31:0]  exp_instr [$];
  logic         exp_err [$];
  logic         exp_short [$];
  // Memory responder state
  fetch_resp_t  resp_q [$];
  int           resp_due [$];
  logic [31:0]  next_waddr;
  logic         branch_taken;
  int           cyc;
  logic [15:0]  lfsr_q;
  int unsigned  errors, checks, failed;

  albuf_top DUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_i              (ctrl),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .instr_valid_o       (instr_valid),
    .instr_ready_i       (instr_ready),
    .instr_o             (instr_out),
    .busy_o              (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr_q   = lfsr_next(lfsr_q);
    take_bit = lfsr_q[0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Program memory, a block of four words per row
  function automatic fetch_resp_t mem_word(input row_t r, input logic [31:0] waddr);
    logic [31:0] off;
    fetch_resp_t w;
    off = waddr - {r.target[31:2], 2'b00};
    if (off < 32'd16) begin
      w.rdata = {r.hw[{off[3:2], 1'b1}], r.hw[{off[3:2], 1'b0}]};
      w.err   = r.err[off[3:2]];
    end else begin
      // Outside the block two compressed halfwords made from the address
      w.rdata = {waddr[16:2], 1'b0, waddr[31:17], 1'b0};
      w.err   = 1'b0;
    end
    mem_word = w;
  endfunction

  function automatic logic [15:0] mem_half(input row_t r, input logic [31:0] a);
    fetch_resp_t w;
    w = mem_word(r, {a[31:2], 2'b00});
    mem_half = a[1] ? w.rdata[31:16] : w.rdata[15:0];
  endfunction

  function automatic logic word_err(input row_t r, input logic [31:0] a);
    fetch_resp_t w;
    w = mem_word(r, {a[31:2], 2'b00});
    word_err = w.err;
  endfunction

  // Walk the halfwords from the target and list every instruction that starts in the block
  task automatic build_expected(input row_t r);
    logic [31:0] a, stop;
    logic [15:0] lo, hi;
    exp_addr.delete();
    exp_instr.delete();
    exp_err.delete();
    exp_short.delete();
    a    = {r.target[31:1], 1'b0};
    stop = {r.target[31:2], 2'b00} + 32'd16;
    while (a < stop) begin
      lo = mem_half(r, a);
      exp_addr.push_back(a);
      if (lo[1:0] != OPCODE_FULL) begin
        exp_instr.push_back({16'h0000, lo});
        exp_err.push_back(word_err(r, a));
        exp_short.push_back(1'b1);
        a = a + 32'd2;
      end else begin
        // Second halfword may sit in the following word
        hi = mem_half(r, a + 32'd2);
        exp_instr.push_back({hi, lo});
        exp_err.push_back(word_err(r, a) | word_err(r, a + 32'd2));
        exp_short.push_back(1'b0);
        a = a + 32'd4;
      end
    end
  endtask

  //////////////////////////////
  // One clock cycle
  //////////////////////////////

  task automatic run_cycle(input logic do_branch, input logic do_kill, input logic rnd,
                           input logic hold);
    int unsigned owed;
    logic        short_instr;
    logic [31:0] got_instr;
    @(negedge clk);
    cyc++;
    ctrl.instr_req = 1'b1;
    ctrl.pc_set    = do_branch;
    ctrl.kill      = do_kill;
    ctrl.target    = cur.target;
    if (rnd) begin
      fetch_ready = take_bit();
    end else begin
      fetch_ready = 1'b1;
    end
    // Decode side stalled while holding
    if (hold) begin
      instr_ready = 1'b0;
    end else if (rnd) begin
      instr_ready = take_bit();
    end else begin
      instr_ready = 1'b1;
    end
    // Words return in order once their latency has passed
    owed       = resp_q.size();
    resp_valid = 1'b0;
    resp       = '0;
    if ((owed != 0) && (resp_due[0] <= cyc)) begin
      resp_valid = 1'b1;
      resp       = resp_q.pop_front();
      void'(resp_due.pop_front());
    end
    #SETTLE;
    if (owed > MAX_OUTSTANDING) begin
      errors++;
      $display("error at %0t: %0d fetch requests outstanding, more than allowed", $time, owed);
    end
    // Busy while a word is owed or a request is offered
    check_value("busy_o", busy, (owed != 0) || fetch_valid);
    check_value("fetch_branch_o", fetch_branch, do_branch);
    // Kill drops the output in the same cycle
    if (do_kill) begin
      check_value("instr_valid_o", instr_valid, 1'b0);
    end
    // Request transfers on the coming rising edge
    if (fetch_valid && fetch_ready) begin
      if (do_branch) begin
        check_value("fetch_branch_addr_o", fetch_branch_addr, {cur.target[31:1], 1'b0});
        next_waddr   = {cur.target[31:2], 2'b00};
        branch_taken = 1'b1;
      end
      resp_q.push_back(mem_word(cur, next_waddr));
      resp_due.push_back(cyc + RESP_LATENCY);
      next_waddr = next_waddr + 32'd4;
    end
    if (instr_valid && instr_ready) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("error at %0t: instruction at %h delivered when none was expected",
                 $time, instr_out.addr);
      end else begin
        short_instr = exp_short.pop_front();
        // Upper half of a compressed instruction is don't care
        got_instr = short_instr ? {16'h0000, instr_out.instr[15:0]} : instr_out.instr;
        check_value("instr_o.addr", instr_out.addr, exp_addr.pop_front());
        check_value("instr_o.instr", got_instr, exp_instr.pop_front());
        check_value("instr_o.err", instr_out.err, exp_err.pop_front());
      end
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing the tests", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////
  // Stimulus table and main loop
  //////////////////////////////

  initial begin : main
    int unsigned row_err;
    int unsigned n_instr;
    rst_n       = 1'b0;
    ctrl        = '0;
    fetch_ready = 1'b0;
    resp_valid  = 1'b0;
    resp        = '0;
    instr_ready = 1'b0;
    lfsr_q      = 16'd44;
    errors      = 0;
    checks      = 0;
    failed      = 0;
    cyc         = 0;
    next_waddr  = '0;
    // Aligned mix with an aligned and a split 32-bit instruction
    rows[0] = {32'h0000_0100, 128'h0001_00f5_07b3_4785_0010_0513_8082_4501, 4'b0000, 2'b00};
    // Unaligned target, split instruction with a faulting second word
    rows[1] = {32'h0000_0202, 128'h40b5_0533_4605_0000_0297_8536_4691_1073, 4'b0100, 2'b00};
    // Random ready, last instruction runs past the block
    rows[2] = {32'h0000_3000, 128'h0e63_4701_0040_0f13_853e_0001_0637_4581, 4'b1000, 2'b01};
    // Unaligned split start with a fault, then kill
    rows[3] = {32'h0000_040a, 128'h4605_00b5_2023_8082_4501_0010_0093_9002, 4'b0001, 2'b11};
    // Restart after kill
    rows[4] = {32'h0000_5000, 128'h8082_4701_8d89_0070_0613_4585_0005_0513, 4'b0000, 2'b00};
    rows[5] = {32'h0000_6002, 128'h0000_0733_4681_8526_4639_0001_05b7_0033, 4'b0010, 2'b01};
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SETTLE;
    // Idle with fetch disabled
    check_value("fetch_valid_o", fetch_valid, 1'b0);
    check_value("instr_valid_o", instr_valid, 1'b0);
    check_value("busy_o", busy, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur = rows[r];
      build_expected(cur);
      n_instr      = exp_addr.size();
      row_err      = errors;
      branch_taken = 1'b0;
      // Branch is held until the bus takes the branch request
      while (exp_addr.size() != 0) begin
        run_cycle(!branch_taken, 1'b0, cur.rand_ready, 1'b0);
      end
      if (cur.kill) begin
        // Stall decode until an instruction waits on the output for kill to drop
        run_cycle(1'b0, 1'b0, cur.rand_ready, 1'b1);
        while (!instr_valid) begin
          run_cycle(1'b0, 1'b0, cur.rand_ready, 1'b1);
        end
        run_cycle(1'b0, 1'b1, cur.rand_ready, 1'b0);
      end
      if (errors == row_err) begin
        $display("test %0d target %h: %0d instructions ok", r, cur.target, n_instr);
      end else begin
        failed++;
        $display("test %0d target %h: %0d errors", r, cur.target, errors - row_err);
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", NUM_ROWS, failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
hdl/albuf_bus_pkg.sv
hdl/albuf_ctrl_pkg.sv
hdl/albuf_fetch_ctrl.sv
hdl/albuf_word_queue.sv
hdl/albuf_aligner.sv
hdl/albuf_top.sv
bench/albuf_tb.sv

//--- Bender.yml
package:
  name: albuf

sources:
  # Packages first, then the three stages and the top level
  - hdl/albuf_bus_pkg.sv
  - hdl/albuf_ctrl_pkg.sv
  - hdl/albuf_fetch_ctrl.sv
  - hdl/albuf_word_queue.sv
  - hdl/albuf_aligner.sv
  - hdl/albuf_top.sv
  - target: test
    files:
      - bench/albuf_tb.sv
